// ==== Makefile ====
TOOL       = verilator
TOP        = tb_audio_menu
FILELIST   = build.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulation binary exits non-zero on $$fatal
sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+hdl
hdl/board_pkg.sv
hdl/button_pulse.sv
hdl/sample_buffer.sv
hdl/peak_meter.sv
hdl/passcode_lock.sv
hdl/mode_control.sv
hdl/audio_menu_top.sv
test/tb_audio_menu.sv

// ==== hdl/audio_menu_top.sv ====
`default_nettype none

`include "board_params.svh"

module audio_menu_top (
    input  wire                  clk,
    input  wire                  reset,
    // Bit 4 center, 3 up, 2 down, 1 left, 0 right
    input  wire [`BTN_N-1:0]     buttons,
    input  wire [`SAMPLE_W-1:0]  sample,
    input  wire                  sample_valid,
    output logic                 sample_credit,
    output board_pkg::mode_t     mode,
    output logic [`LED_W-1:0]    led,
    output logic [`SEG_W-1:0]    seg
);

    // Debounced press codes
    board_pkg::button_t   pulse_code;

    // FIFO head into the meter
    logic [`SAMPLE_W-1:0] fifo_sample;
    logic                 fifo_valid;

    // Meter result per window
    logic [`LEVEL_W-1:0]  level;
    logic                 level_valid;

    // Lock handshake with the mode FSM
    logic                 unlock;
    logic [1:0]           progress;
    logic                 armed;

    button_pulse u_button_pulse (
        .clk        (clk),
        .reset      (reset),
        .buttons    (buttons),
        .pulse_code (pulse_code)
    );

    sample_buffer u_sample_buffer (
        .clk           (clk),
        .reset         (reset),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .sample_credit (sample_credit),
        .fifo_sample   (fifo_sample),
        .fifo_valid    (fifo_valid)
    );

    peak_meter u_peak_meter (
        .clk         (clk),
        .reset       (reset),
        .fifo_sample (fifo_sample),
        .fifo_valid  (fifo_valid),
        .level       (level),
        .level_valid (level_valid)
    );

    passcode_lock u_passcode_lock (
        .clk        (clk),
        .reset      (reset),
        .armed      (armed),
        .pulse_code (pulse_code),
        .unlock     (unlock),
        .progress   (progress)
    );

    mode_control u_mode_control (
        .clk         (clk),
        .reset       (reset),
        .pulse_code  (pulse_code),
        .unlock      (unlock),
        .progress    (progress),
        .level       (level),
        .level_valid (level_valid),
        .armed       (armed),
        .mode        (mode),
        .led         (led),
        .seg         (seg)
    );

endmodule

`default_nettype wire

// ==== hdl/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Microphone sample and volume level widths
`define SAMPLE_W     12
`define LEVEL_W      4

// One LED per level step
`define LED_W        16

// Segments a to g, active low
`define SEG_W        7

// Field widths of the board_pkg enums
`define MODE_W       2
`define BTN_W        3

// Center, up, down, left, right
`define BTN_N        5

// Samples per metering window
`define WINDOW_LEN   16

// FIFO depth, also the sender's credits after reset
`define CREDIT_MAX   4

// Stable-high cycles before a press counts
`define DEBOUNCE_LEN 4

// Unlock sequence, first press first
`define PASS_0       board_pkg::BTN_UP
`define PASS_1       board_pkg::BTN_DOWN
`define PASS_2       board_pkg::BTN_LEFT
`define PASS_3       board_pkg::BTN_RIGHT

`endif

// ==== hdl/board_pkg.sv ====
`default_nettype none

`include "board_params.svh"

package board_pkg;

    // Top level operating mode
    typedef enum logic [`MODE_W-1:0] {
        MODE_LOCKED = 2'd0,
        MODE_MENU   = 2'd1,
        MODE_LIVE   = 2'd2,
        MODE_HOLD   = 2'd3
    } mode_t;

    // Code of a debounced press, BTN_NONE when idle
    typedef enum logic [`BTN_W-1:0] {
        BTN_NONE   = 3'd0,
        BTN_UP     = 3'd1,
        BTN_DOWN   = 3'd2,
        BTN_LEFT   = 3'd3,
        BTN_RIGHT  = 3'd4,
        BTN_CENTER = 3'd5
    } button_t;

endpackage

`default_nettype wire

// ==== hdl/button_pulse.sv ====
`default_nettype none

`include "board_params.svh"

module button_pulse (
    input  wire                clk,
    input  wire                reset,
    // Bit 4 center, 3 up, 2 down, 1 left, 0 right
    input  wire [`BTN_N-1:0]   buttons,
    output board_pkg::button_t pulse_code
);

    // Bit positions in the button vector
    localparam int B_CENTER = 4;
    localparam int B_UP     = 3;
    localparam int B_DOWN   = 2;
    localparam int B_LEFT   = 1;
    localparam int B_RIGHT  = 0;

    // Counter saturates at DEBOUNCE_LEN
    localparam int CNT_W = $clog2(`DEBOUNCE_LEN + 1);

    logic [`BTN_N-1:0] buttons_q;
    logic [CNT_W-1:0]  stable_cnt [`BTN_N];
    logic [`BTN_N-1:0] fire;
    logic [`BTN_N-1:0] pending;
    logic [`BTN_N-1:0] ready;
    logic [`BTN_N-1:0] chosen;
    board_pkg::button_t code_next;

    // Counter about to reach DEBOUNCE_LEN
    always_comb begin
        for (int i = 0; i < `BTN_N; i++) begin
            fire[i] = buttons_q[i] && (stable_cnt[i] == CNT_W'(`DEBOUNCE_LEN - 1));
        end
    end

    // Presses waiting for an idle output cycle
    assign ready = pending | fire;

    //////////////////////////////
    // Priority pick
    //////////////////////////////

    // Only after an idle cycle, so every code is followed by BTN_NONE
    always_comb begin
        chosen    = '0;
        code_next = board_pkg::BTN_NONE;
        if (pulse_code == board_pkg::BTN_NONE) begin
            if (ready[B_CENTER]) begin
                chosen[B_CENTER] = 1'b1;
                code_next        = board_pkg::BTN_CENTER;
            end else if (ready[B_UP]) begin
                chosen[B_UP] = 1'b1;
                code_next    = board_pkg::BTN_UP;
            end else if (ready[B_DOWN]) begin
                chosen[B_DOWN] = 1'b1;
                code_next      = board_pkg::BTN_DOWN;
            end else if (ready[B_LEFT]) begin
                chosen[B_LEFT] = 1'b1;
                code_next      = board_pkg::BTN_LEFT;
            end else if (ready[B_RIGHT]) begin
                chosen[B_RIGHT] = 1'b1;
                code_next       = board_pkg::BTN_RIGHT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buttons_q  <= '0;
            pending    <= '0;
            pulse_code <= board_pkg::BTN_NONE;
            for (int i = 0; i < `BTN_N; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            buttons_q  <= buttons;
            pending    <= ready & ~chosen;
            pulse_code <= code_next;
            for (int i = 0; i < `BTN_N; i++) begin
                // Release rearms the button
                if (!buttons_q[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] != CNT_W'(`DEBOUNCE_LEN)) begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Consumers see at most one press code in a row
    a_pulse_gap: assert property (@(posedge clk) disable iff (reset)
        pulse_code != board_pkg::BTN_NONE |=> pulse_code == board_pkg::BTN_NONE);

endmodule

`default_nettype wire

// ==== hdl/mode_control.sv ====
`default_nettype none

`include "board_params.svh"

module mode_control (
    input  wire                     clk,
    input  wire                     reset,
    input  wire board_pkg::button_t pulse_code,
    input  wire                     unlock,
    input  wire [1:0]               progress,
    input  wire [`LEVEL_W-1:0]      level,
    input  wire                     level_valid,
    output logic                    armed,
    output board_pkg::mode_t        mode,
    output logic [`LED_W-1:0]       led,
    output logic [`SEG_W-1:0]       seg
);

    board_pkg::mode_t    mode_next;
    logic                cursor;
    logic                cursor_next;
    logic [`LEVEL_W-1:0] live_level;
    logic [`LEVEL_W-1:0] live_next;
    logic [`LEVEL_W-1:0] hold_level;
    logic [`LEVEL_W-1:0] hold_next;
    logic [`LEVEL_W-1:0] digit;
    logic [`LED_W-1:0]   led_next;

    // Low lvl bits set
    function automatic logic [`LED_W-1:0] thermo(input logic [`LEVEL_W-1:0] lvl);
        thermo = (`LED_W'(1) << lvl) - 1'b1;
    endfunction

    // Hex digit, segments a in bit 0 to g in bit 6, active low
    function automatic logic [`SEG_W-1:0] hex_seg(input logic [`LEVEL_W-1:0] d);
        case (d)
            4'h0:    hex_seg = 7'b1000000;
            4'h1:    hex_seg = 7'b1111001;
            4'h2:    hex_seg = 7'b0100100;
            4'h3:    hex_seg = 7'b0110000;
            4'h4:    hex_seg = 7'b0011001;
            4'h5:    hex_seg = 7'b0010010;
            4'h6:    hex_seg = 7'b0000010;
            4'h7:    hex_seg = 7'b1111000;
            4'h8:    hex_seg = 7'b0000000;
            4'h9:    hex_seg = 7'b0010000;
            4'ha:    hex_seg = 7'b0001000;
            4'hb:    hex_seg = 7'b0000011;
            4'hc:    hex_seg = 7'b1000110;
            4'hd:    hex_seg = 7'b0100001;
            4'he:    hex_seg = 7'b0000110;
            default: hex_seg = 7'b0001110;
        endcase
    endfunction

    // Lock listens only before unlock
    assign armed = (mode == board_pkg::MODE_LOCKED);

    //////////////////////////////
    // Mode FSM and cursor
    //////////////////////////////

    always_comb begin
        mode_next   = mode;
        cursor_next = cursor;
        unique case (mode)
            board_pkg::MODE_LOCKED: begin
                if (unlock) begin
                    mode_next = board_pkg::MODE_MENU;
                end
            end
            board_pkg::MODE_MENU: begin
                // Two entries, so up and down both flip
                if (pulse_code == board_pkg::BTN_UP || pulse_code == board_pkg::BTN_DOWN) begin
                    cursor_next = ~cursor;
                end else if (pulse_code == board_pkg::BTN_CENTER) begin
                    mode_next = cursor ? board_pkg::MODE_HOLD : board_pkg::MODE_LIVE;
                end
            end
            default: begin
                // Live or hold view
                if (pulse_code == board_pkg::BTN_CENTER) begin
                    mode_next = board_pkg::MODE_MENU;
                end
            end
        endcase
    end

    // Last level, and peak hold since entering HOLD
    always_comb begin
        live_next = level_valid ? level : live_level;
        if (mode_next == board_pkg::MODE_HOLD && mode != board_pkg::MODE_HOLD) begin
            hold_next = '0;
        end else if (mode == board_pkg::MODE_HOLD && level_valid && level > hold_level) begin
            hold_next = level;
        end else begin
            hold_next = hold_level;
        end
    end

    //////////////////////////////
    // LED and digit select
    //////////////////////////////

    // Built from next values, so outputs line up with mode
    always_comb begin
        unique case (mode_next)
            board_pkg::MODE_LOCKED: begin
                led_next = '0;
                digit    = `LEVEL_W'(progress);
            end
            board_pkg::MODE_MENU: begin
                led_next = `LED_W'(1) << cursor_next;
                digit    = `LEVEL_W'(cursor_next);
            end
            board_pkg::MODE_LIVE: begin
                led_next = thermo(live_next);
                digit    = live_next;
            end
            default: begin
                led_next = thermo(hold_next);
                digit    = hold_next;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode       <= board_pkg::MODE_LOCKED;
            cursor     <= 1'b0;
            live_level <= '0;
            hold_level <= '0;
            led        <= '0;
            seg        <= hex_seg('0);
        end else begin
            mode       <= mode_next;
            cursor     <= cursor_next;
            live_level <= live_next;
            hold_level <= hold_next;
            led        <= led_next;
            seg        <= hex_seg(digit);
        end
    end

    // The lock pulse is the only way out of LOCKED
    a_locked_until_unlock: assert property (@(posedge clk) disable iff (reset)
        (mode == board_pkg::MODE_LOCKED && !unlock) |=> mode == board_pkg::MODE_LOCKED);

endmodule

`default_nettype wire

// ==== hdl/passcode_lock.sv ====
`default_nettype none

`include "board_params.svh"

module passcode_lock (
    input  wire                clk,
    input  wire                reset,
    input  wire                armed,
    input  wire board_pkg::button_t pulse_code,
    output logic               unlock,
    output logic [1:0]         progress
);

    // One state per expected press
    typedef enum logic [1:0] {
        WAIT_0 = 2'd0,
        WAIT_1 = 2'd1,
        WAIT_2 = 2'd2,
        WAIT_3 = 2'd3
    } pass_state_t;

    pass_state_t        state;
    board_pkg::button_t expected;

    // Press the current state waits for
    always_comb begin
        unique case (state)
            WAIT_0:  expected = `PASS_0;
            WAIT_1:  expected = `PASS_1;
            WAIT_2:  expected = `PASS_2;
            default: expected = `PASS_3;
        endcase
    end

    // Correct presses so far
    assign progress = state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= WAIT_0;
            unlock <= 1'b0;
        end else begin
            unlock <= 1'b0;
            if (armed && pulse_code != board_pkg::BTN_NONE) begin
                if (pulse_code != expected) begin
                    // Wrong press is dropped, no restart on it
                    state <= WAIT_0;
                end else if (state == WAIT_3) begin
                    unlock <= 1'b1;
                    state  <= WAIT_0;
                end else begin
                    state <= pass_state_t'(state + 1'b1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/peak_meter.sv ====
`default_nettype none

`include "board_params.svh"

module peak_meter (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [`SAMPLE_W-1:0]  fifo_sample,
    input  wire                  fifo_valid,
    output logic [`LEVEL_W-1:0]  level,
    output logic                 level_valid
);

    // Magnitude drops the sign of the offset
    localparam int MAG_W = `SAMPLE_W - 1;
    localparam int IDX_W = $clog2(`WINDOW_LEN);

    // Mid-scale 2048
    localparam logic [`SAMPLE_W-1:0] MID = {1'b1, {MAG_W{1'b0}}};

    logic [`SAMPLE_W-1:0] below;
    logic [MAG_W-1:0]     mag;
    logic [MAG_W-1:0]     peak;
    logic [MAG_W-1:0]     peak_next;
    logic [IDX_W-1:0]     sample_idx;

    //////////////////////////////
    // Magnitude and running peak
    //////////////////////////////

    always_comb begin
        below = MID - fifo_sample;
        if (fifo_sample[`SAMPLE_W-1]) begin
            // Upper half, offset is just the low bits
            mag = fifo_sample[MAG_W-1:0];
        end else if (below[MAG_W]) begin
            // Sample 0 would give 2048, clamp to full scale
            mag = '1;
        end else begin
            mag = below[MAG_W-1:0];
        end
        peak_next = (mag > peak) ? mag : peak;
    end

    //////////////////////////////
    // Window bookkeeping
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            peak        <= '0;
            sample_idx  <= '0;
            level       <= '0;
            level_valid <= 1'b0;
        end else begin
            level_valid <= 1'b0;
            if (fifo_valid) begin
                if (sample_idx == IDX_W'(`WINDOW_LEN - 1)) begin
                    // Window closes, top bits become the level
                    level       <= peak_next[MAG_W-1 -: `LEVEL_W];
                    level_valid <= 1'b1;
                    peak        <= '0;
                    sample_idx  <= '0;
                end else begin
                    peak       <= peak_next;
                    sample_idx <= sample_idx + 1'b1;
                end
            end
        end
    end

    // Level only ever follows a sample leaving the FIFO
    a_level_after_pop: assert property (@(posedge clk) disable iff (reset)
        level_valid |-> $past(fifo_valid));

endmodule

`default_nettype wire

// ==== hdl/sample_buffer.sv ====
`default_nettype none

`include "board_params.svh"

module sample_buffer (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [`SAMPLE_W-1:0]  sample,
    input  wire                  sample_valid,
    output logic                 sample_credit,
    output logic [`SAMPLE_W-1:0] fifo_sample,
    output logic                 fifo_valid
);

    localparam int PTR_W = $clog2(`CREDIT_MAX);
    localparam int CNT_W = $clog2(`CREDIT_MAX + 1);

    logic [`SAMPLE_W-1:0] mem [`CREDIT_MAX];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fill;
    logic                 push;
    logic                 pop;

    // Sender only sends with a credit in hand
    assign push = sample_valid;

    // Meter never stalls, head leaves as soon as it shows
    assign pop = fifo_valid;

    assign fifo_valid  = (fill != '0);
    assign fifo_sample = mem[rd_ptr];

    // Circular pointer step
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(`CREDIT_MAX - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample;
        end
    end

    //////////////////////////////
    // Pointers, fill, credits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            sample_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill <= fill + CNT_W'(push) - CNT_W'(pop);
            // One credit back per freed entry, a cycle after the pop
            sample_credit <= pop;
        end
    end

    // Full FIFO plus a push means the sender overspent its credits
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> fill != CNT_W'(`CREDIT_MAX));

endmodule

`default_nettype wire

// ==== test/tb_audio_menu.sv ====
`default_nettype none

`include "board_params.svh"

module tb_audio_menu;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int HOLD_CYCLES   = 10;
    localparam int N_PRESSES     = 15;
    localparam int N_WINDOWS     = 12;
    localparam int PRESS_CYCLES  = 2 * HOLD_CYCLES + 2;
    localparam int WINDOW_CYCLES = 4 * `WINDOW_LEN;
    // Twice the expected run length
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + 2 + N_PRESSES * PRESS_CYCLES + N_WINDOWS * WINDOW_CYCLES);

    logic                   clk;
    logic                   reset;
    logic [`BTN_N-1:0]      buttons;
    logic [`SAMPLE_W-1:0]   sample;
    logic                   sample_valid;
    logic                   sample_credit;
    board_pkg::mode_t       mode;
    logic [`LED_W-1:0]      led;
    logic [`SEG_W-1:0]      seg;

    // Reference model state
    board_pkg::mode_t       exp_mode;
    int                     exp_progress;
    logic                   exp_cursor;
    int                     exp_live;
    int                     exp_hold;
    logic [`LED_W-1:0]      exp_led;
    logic [`SEG_W-1:0]      exp_seg;

    // Check strobes, raised for one cycle
    logic                   check_en;
    logic                   reset_check_en;

    // Credit bookkeeping of the sender
    int                     sent_count;
    int                     credit_count;
    logic [31:0]            rng_state;
    int                     window_level;
    logic [31:0]            rnd;

    audio_menu_top u_audio_menu_top (
        .clk           (clk),
        .reset         (reset),
        .buttons       (buttons),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .sample_credit (sample_credit),
        .mode          (mode),
        .led           (led),
        .seg           (seg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Model helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Distance from mid-scale, full scale is 2047
    function automatic int sample_magnitude(input logic [`SAMPLE_W-1:0] s);
        int m;
        m = (s >= 12'd2048) ? int'(s) - 2048 : 2048 - int'(s);
        if (m > 2047) begin
            m = 2047;
        end
        return m;
    endfunction

    function automatic logic [`LED_W-1:0] thermometer(input int lvl);
        logic [`LED_W-1:0] t;
        t = '0;
        for (int i = 0; i < `LED_W; i++) begin
            t[i] = (i < lvl);
        end
        return t;
    endfunction

    // Standard lit-segment codes, then inverted for the active-low digit
    function automatic logic [`SEG_W-1:0] hex_segments(input int d);
        logic [`SEG_W-1:0] lit;
        case (d)
            0:       lit = 7'h3f;
            1:       lit = 7'h06;
            2:       lit = 7'h5b;
            3:       lit = 7'h4f;
            4:       lit = 7'h66;
            5:       lit = 7'h6d;
            6:       lit = 7'h7d;
            7:       lit = 7'h07;
            8:       lit = 7'h7f;
            9:       lit = 7'h6f;
            10:      lit = 7'h77;
            11:      lit = 7'h7c;
            12:      lit = 7'h39;
            13:      lit = 7'h5e;
            14:      lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // Bit 4 center, 3 up, 2 down, 1 left, 0 right
    function automatic logic [`BTN_N-1:0] button_bit(input board_pkg::button_t code);
        case (code)
            board_pkg::BTN_CENTER: return 5'b10000;
            board_pkg::BTN_UP:     return 5'b01000;
            board_pkg::BTN_DOWN:   return 5'b00100;
            board_pkg::BTN_LEFT:   return 5'b00010;
            board_pkg::BTN_RIGHT:  return 5'b00001;
            default:               return 5'b00000;
        endcase
    endfunction

    function automatic board_pkg::button_t pass_press(input int idx);
        case (idx)
            0:       return `PASS_0;
            1:       return `PASS_1;
            2:       return `PASS_2;
            default: return `PASS_3;
        endcase
    endfunction

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // Every drive lands 1 unit after the edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic apply_press_model(input board_pkg::button_t code);
        case (exp_mode)
            board_pkg::MODE_LOCKED: begin
                if (code != pass_press(exp_progress)) begin
                    exp_progress = 0;
                end else if (exp_progress == 3) begin
                    exp_progress = 0;
                    exp_mode     = board_pkg::MODE_MENU;
                end else begin
                    exp_progress++;
                end
            end
            board_pkg::MODE_MENU: begin
                if (code == board_pkg::BTN_UP || code == board_pkg::BTN_DOWN) begin
                    exp_cursor = ~exp_cursor;
                end else if (code == board_pkg::BTN_CENTER) begin
                    if (exp_cursor) begin
                        exp_mode = board_pkg::MODE_HOLD;
                        exp_hold = 0;
                    end else begin
                        exp_mode = board_pkg::MODE_LIVE;
                    end
                end
            end
            default: begin
                if (code == board_pkg::BTN_CENTER) begin
                    exp_mode = board_pkg::MODE_MENU;
                end
            end
        endcase
    endtask

    // Expected view per mode, compared on the next edge
    task automatic check_outputs();
        case (exp_mode)
            board_pkg::MODE_LOCKED: begin
                exp_led = '0;
                exp_seg = hex_segments(exp_progress);
            end
            board_pkg::MODE_MENU: begin
                exp_led             = '0;
                exp_led[exp_cursor] = 1'b1;
                exp_seg             = hex_segments(int'(exp_cursor));
            end
            board_pkg::MODE_LIVE: begin
                exp_led = thermometer(exp_live);
                exp_seg = hex_segments(exp_live);
            end
            default: begin
                exp_led = thermometer(exp_hold);
                exp_seg = hex_segments(exp_hold);
            end
        endcase
        check_en = 1'b1;
        wait_cycle();
        check_en = 1'b0;
    endtask

    task automatic press_button(input board_pkg::button_t code);
        buttons = button_bit(code);
        repeat (HOLD_CYCLES) wait_cycle();
        buttons = '0;
        repeat (HOLD_CYCLES) wait_cycle();
        apply_press_model(code);
        check_outputs();
    endtask

    // Sender side of the credit flow
    task automatic send_sample(input logic [`SAMPLE_W-1:0] s);
        while (sent_count - credit_count >= `CREDIT_MAX) begin
            wait_cycle();
        end
        sample       = s;
        sample_valid = 1'b1;
        sent_count++;
        wait_cycle();
        sample_valid = 1'b0;
    endtask

    task automatic wait_credits();
        while (credit_count != sent_count) begin
            wait_cycle();
        end
    endtask

    // One window around mid-scale, peak offset below amp
    task automatic send_window(input int amp, output int lvl);
        int                   peak;
        int                   offset;
        logic [31:0]          r;
        logic [`SAMPLE_W-1:0] s;
        peak = 0;
        for (int n = 0; n < `WINDOW_LEN; n++) begin
            draw_random(r);
            offset = int'(r[15:0]) % amp;
            s      = r[31] ? 12'(2048 + offset) : 12'(2048 - offset);
            if (sample_magnitude(s) > peak) begin
                peak = sample_magnitude(s);
            end
            send_sample(s);
        end
        // Top four of the eleven magnitude bits
        lvl = peak / 128;
    endtask

    task automatic run_window(input int amp);
        send_window(amp, window_level);
        wait_credits();
        exp_live = window_level;
        if (exp_mode == board_pkg::MODE_HOLD && window_level > exp_hold) begin
            exp_hold = window_level;
        end
        check_outputs();
    endtask

    // Credits arrive as a registered pulse
    always @(posedge clk) begin
        if (reset) begin
            credit_count <= 0;
        end else if (sample_credit) begin
            credit_count <= credit_count + 1;
        end
    end

    //////////////////////////////
    // Checking assertions
    //////////////////////////////

    a_mode: assert property (@(posedge clk) disable iff (reset)
        check_en |-> mode == exp_mode)
        else begin
            $display("ERROR at %0t: mode expected %0d got %0d",
                $time, $sampled(exp_mode), $sampled(mode));
            $display("=== FAIL ===");
            $fatal(1, "mode mismatch");
        end

    a_led: assert property (@(posedge clk) disable iff (reset)
        check_en |-> led == exp_led)
        else begin
            $display("ERROR at %0t: led expected %h got %h",
                $time, $sampled(exp_led), $sampled(led));
            $display("=== FAIL ===");
            $fatal(1, "led mismatch");
        end

    a_seg: assert property (@(posedge clk) disable iff (reset)
        check_en |-> seg == exp_seg)
        else begin
            $display("ERROR at %0t: seg expected %b got %b",
                $time, $sampled(exp_seg), $sampled(seg));
            $display("=== FAIL ===");
            $fatal(1, "seg mismatch");
        end

    a_credit_idle: assert property (@(posedge clk) disable iff (reset)
        reset_check_en |-> !sample_credit)
        else begin
            $display("ERROR at %0t: sample_credit expected 0 got 1 after reset", $time);
            $display("=== FAIL ===");
            $fatal(1, "credit after reset");
        end

    // No credit without a sample in flight
    a_credit_earned: assert property (@(posedge clk) disable iff (reset)
        sample_credit |-> credit_count < sent_count)
        else begin
            $display("ERROR at %0t: sample_credit pulsed with %0d sent and %0d credited",
                $time, $sampled(sent_count), $sampled(credit_count));
            $display("=== FAIL ===");
            $fatal(1, "unearned credit");
        end

    // One cycle into the FIFO, one out, then the credit pulse
    a_credit_latency: assert property (@(posedge clk) disable iff (reset)
        sample_credit == $past(sample_valid, 2))
        else begin
            $display("ERROR at %0t: sample_credit expected %0b got %0b",
                $time, !$sampled(sample_credit), $sampled(sample_credit));
            $display("=== FAIL ===");
            $fatal(1, "credit timing");
        end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        reset          = 1'b1;
        buttons        = '0;
        sample         = '0;
        sample_valid   = 1'b0;
        check_en       = 1'b0;
        reset_check_en = 1'b0;
        sent_count     = 0;
        rng_state      = 32'h7c860c4a;
        exp_mode       = board_pkg::MODE_LOCKED;
        exp_progress   = 0;
        exp_cursor     = 1'b0;
        exp_live       = 0;
        exp_hold       = 0;
        exp_led        = '0;
        exp_seg        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle board after reset
        reset_check_en = 1'b1;
        check_outputs();
        reset_check_en = 1'b0;

        // Wrong code stays locked
        press_button(board_pkg::BTN_UP);
        press_button(board_pkg::BTN_UP);
        press_button(board_pkg::BTN_LEFT);
        press_button(board_pkg::BTN_RIGHT);

        // Correct code opens the menu
        press_button(`PASS_0);
        press_button(`PASS_1);
        press_button(`PASS_2);
        press_button(`PASS_3);

        // Cursor both ways, then live view
        press_button(board_pkg::BTN_DOWN);
        press_button(board_pkg::BTN_UP);
        press_button(board_pkg::BTN_CENTER);
        for (int w = 0; w < 6; w++) begin
            draw_random(rnd);
            run_window(1 + int'(rnd[10:0]));
        end

        // Back to menu, cursor to hold
        press_button(board_pkg::BTN_CENTER);
        press_button(board_pkg::BTN_DOWN);
        press_button(board_pkg::BTN_CENTER);

        // Loud then quiet, held level must not drop
        for (int k = 0; k < 3; k++) begin
            run_window(600 * (k + 1));
            run_window(100);
        end
        press_button(board_pkg::BTN_CENTER);

        wait_credits();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
